//--- hdl/udp_lb_pkg.sv
`default_nettype none

package udp_lb_pkg;

	localparam logic [15:0] LOCAL_PORT = 16'hd002;	// udp port answered by the bridge

	// transmit buffer, counted in 64-bit local bus words
	localparam int TX_FIFO_WORDS = 8;
	localparam int TX_FIFO_AW = $clog2(TX_FIFO_WORDS);

	localparam logic [15:0] UDP_HDR_BYTES = 16'd8;	// udp header, not part of the payload

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_TAIL
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_REQUEST,
		TX_REQACK,
		TX_START,
		TX_DATA,
		TX_TAIL
	} tx_state_t;

endpackage

`default_nettype wire

//--- hdl/udp_lb_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// payload bytes from the port filter to the word packer
interface udp_byte_if;
	logic [7:0] data;
	logic       dven;	// one payload byte per cycle
	logic       error;	// byte came in with rx_error
	logic       last;	// single cycle after the final byte, dven low

	modport source (output data, dven, error, last);
	modport sink (input data, dven, error, last);
endinterface

// byte-wide read side of the transmit buffer
interface fifo_rd_if;
	logic       rd_en;
	logic [7:0] data;
	logic       valid;	// data answers the rd_en of the previous cycle
	logic       empty;

	modport source (input rd_en, output data, valid, empty);
	modport sink (output rd_en, input data, valid, empty);
endinterface

`default_nettype wire

//--- hdl/udp_rx_port_filter.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_port_filter
	import udp_lb_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        rx_newhead,
	input  logic        rx_dven,
	input  logic        rx_error,
	input  logic [7:0]  rx_data,
	input  logic [15:0] rx_dstport,
	input  logic [15:0] rx_srcport,
	input  logic [15:0] rx_length,
	output logic [15:0] reply_srcport,
	output logic [15:0] reply_dstport,
	output logic [15:0] rx_payload_length,
	output logic [15:0] rx_err_count,
	udp_byte_if.source  bytes
);

	rx_state_t   state;
	rx_state_t   state_nxt;
	logic        accept;
	logic        got_byte;	// payload has started in this frame
	logic [15:0] udp_length;

	// only a header addressed to us starts a frame
	assign accept = (state == RX_IDLE) && rx_newhead && (rx_dstport == LOCAL_PORT);

	always_comb begin
		state_nxt = state;
		case (state)
			RX_IDLE: state_nxt = accept ? RX_DATA : RX_IDLE;
			RX_DATA: state_nxt = (got_byte && !rx_dven) ? RX_TAIL : RX_DATA;
			RX_TAIL: state_nxt = RX_IDLE;
			default: state_nxt = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			got_byte <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == RX_DATA)
				got_byte <= got_byte | rx_dven;
			else
				got_byte <= 1'b0;
		end
	end

	// reply goes back with the two ports swapped
	always_ff @(posedge clk) begin
		if (accept) begin
			reply_srcport <= rx_dstport;
			reply_dstport <= rx_srcport;
			udp_length <= rx_length;
		end
	end

	assign rx_payload_length = udp_length - UDP_HDR_BYTES;

	always_ff @(posedge clk) begin
		if (reset) begin
			bytes.dven <= 1'b0;
			bytes.error <= 1'b0;
		end else begin
			bytes.dven <= (state == RX_DATA) && rx_dven;
			bytes.error <= (state == RX_DATA) && rx_dven && rx_error;
		end
	end

	always_ff @(posedge clk)
		bytes.data <= rx_data;	// one cycle behind the engine

	assign bytes.last = (state == RX_TAIL);

	// per-frame error count, held until the next accepted header
	always_ff @(posedge clk) begin
		if (reset)
			rx_err_count <= '0;
		else if (accept)
			rx_err_count <= '0;
		else if (bytes.dven && bytes.error)
			rx_err_count <= rx_err_count + 16'd1;
	end

	// last closes a frame that delivered bytes and never overlaps one
	a_last_after_data: assert property (@(posedge clk) disable iff (reset)
		bytes.last |-> !bytes.dven && $past(bytes.dven));

endmodule

`default_nettype wire

//--- hdl/rx_word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module rx_word_packer (
	input  logic        clk,
	input  logic        reset,
	udp_byte_if.sink    bytes,
	output logic [63:0] lb_rx_data,
	output logic        lb_rx_dv
);

	logic [2:0]  byte_idx;	// next byte lane, lsb first
	logic [63:0] word;
	logic        word_full;
	logic        flush;

	assign word_full = bytes.dven && (byte_idx == 3'd7);
	assign flush = !bytes.dven && bytes.last && (byte_idx != 3'd0);

	// word is kept cleared between uses so a flushed word reads zero above the data
	always_ff @(posedge clk) begin
		if (reset) begin
			byte_idx <= '0;
			word <= '0;
			lb_rx_dv <= 1'b0;
		end else begin
			lb_rx_dv <= word_full || flush;
			if (bytes.dven) begin
				byte_idx <= byte_idx + 3'd1;
				if (word_full)
					word <= '0;
				else
					word[byte_idx*8 +: 8] <= bytes.data;
			end else if (flush) begin
				byte_idx <= '0;
				word <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_full)
			lb_rx_data <= {bytes.data, word[55:0]};
		else if (flush)
			lb_rx_data <= word;
	end

	a_dv_single: assert property (@(posedge clk) disable iff (reset)
		lb_rx_dv |=> !lb_rx_dv);

endmodule

`default_nettype wire

//--- hdl/tx_word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module tx_word_fifo
	import udp_lb_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [63:0] lb_tx_data,
	input  logic        lb_tx_en,
	fifo_rd_if.source   rd
);

	logic [63:0]           mem [TX_FIFO_WORDS];
	logic [TX_FIFO_AW-1:0] wr_ptr;
	logic [TX_FIFO_AW-1:0] rd_ptr;
	logic [TX_FIFO_AW:0]   words;	// words with at least one unread byte
	logic [2:0]            byte_sel;	// byte lane of the word under rd_ptr
	logic                  full;
	logic                  wr_ok;
	logic                  rd_ok;
	logic                  word_done;

	assign full = (words == (TX_FIFO_AW+1)'(TX_FIFO_WORDS));
	assign rd.empty = (words == '0);
	assign wr_ok = lb_tx_en && !full;	// writes while full are lost
	assign rd_ok = rd.rd_en && !rd.empty;
	assign word_done = rd_ok && (byte_sel == 3'd7);

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr] <= lb_tx_data;
	end

	always_ff @(posedge clk) begin
		if (rd_ok)
			rd.data <= mem[rd_ptr][byte_sel*8 +: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			words <= '0;
			byte_sel <= '0;
			rd.valid <= 1'b0;
		end else begin
			rd.valid <= rd_ok;
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				byte_sel <= byte_sel + 3'd1;
			if (word_done)
				rd_ptr <= rd_ptr + 1'b1;	// word retires after its 8th byte
			case ({wr_ok, word_done})
				2'b10:   words <= words + 1'b1;
				2'b01:   words <= words - 1'b1;
				default: words <= words;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		lb_tx_en |-> !full)
		else $error("tx_word_fifo: local bus write while full, word dropped");

endmodule

`default_nettype wire

//--- hdl/udp_tx_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_sequencer
	import udp_lb_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] tx_length,
	input  logic        udp_ack,
	fifo_rd_if.sink     rd,
	output logic        udp_request,
	output logic [7:0]  tx_data,
	output logic        tx_dven,
	output logic        tx_error,
	output logic [15:0] tx_udp_length
);

	tx_state_t   state;
	tx_state_t   state_nxt;
	logic [15:0] byte_cnt;	// bytes still owed to the engine
	logic [15:0] rd_left;	// fifo reads not issued yet

	always_comb begin
		state_nxt = state;
		case (state)
			TX_IDLE:    state_nxt = rd.empty ? TX_IDLE : TX_REQUEST;
			TX_REQUEST: state_nxt = TX_REQACK;
			TX_REQACK:  state_nxt = udp_ack ? TX_START : TX_REQACK;
			TX_START:   state_nxt = TX_DATA;
			// stop on the final byte or when the buffer ran dry
			TX_DATA:    state_nxt = (!rd.valid || byte_cnt == 16'd1) ? TX_TAIL : TX_DATA;
			TX_TAIL:    state_nxt = TX_IDLE;
			default:    state_nxt = TX_IDLE;
		endcase
	end

	// one read per cycle from TX_START on, halted as soon as a read comes back empty
	always_comb begin
		if (state == TX_START)
			rd.rd_en = (tx_length != 16'd0);
		else
			rd.rd_en = (state == TX_DATA) && rd.valid && (rd_left != 16'd0);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= TX_IDLE;
			byte_cnt <= '0;
			rd_left <= '0;
		end else begin
			state <= state_nxt;
			if (state == TX_START) begin
				byte_cnt <= tx_length;
				rd_left <= tx_length - {15'd0, rd.rd_en};
			end else begin
				if (tx_dven)
					byte_cnt <= byte_cnt - 16'd1;
				if (rd.rd_en)
					rd_left <= rd_left - 16'd1;
			end
		end
	end

	assign udp_request = (state == TX_REQUEST);
	assign tx_dven = (state == TX_DATA) && rd.valid;
	assign tx_data = rd.data;
	assign tx_error = (state == TX_TAIL) && (byte_cnt != 16'd0);	// frame ran short
	assign tx_udp_length = tx_length + UDP_HDR_BYTES;

	// never more bytes to the engine than the latched frame length
	a_dven_owed: assert property (@(posedge clk) disable iff (reset)
		tx_dven |-> byte_cnt != 16'd0);

endmodule

`default_nettype wire

//--- hdl/udp_lb_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module udp_lb_bridge (
	input  logic        clk,
	input  logic        reset,
	// engine receive side
	input  logic        rx_newhead,
	input  logic        rx_dven,
	input  logic        rx_error,
	input  logic [7:0]  rx_data,
	input  logic [15:0] rx_dstport,
	input  logic [15:0] rx_srcport,
	input  logic [15:0] rx_length,
	// engine transmit side
	output logic [15:0] tx_srcport,
	output logic [15:0] tx_dstport,
	output logic [15:0] tx_udp_length,
	output logic [7:0]  tx_data,
	output logic        tx_dven,
	output logic        tx_error,
	output logic        udp_request,
	input  logic        udp_ack,
	input  logic [15:0] tx_length,
	// local bus
	output logic [63:0] lb_rx_data,
	output logic        lb_rx_dv,
	input  logic [63:0] lb_tx_data,
	input  logic        lb_tx_en,
	output logic [15:0] rx_payload_length,
	output logic [15:0] rx_err_count
);

	udp_byte_if rx_bytes ();
	fifo_rd_if  tx_rd ();

	udp_rx_port_filter u_filter (
		.clk               (clk),
		.reset             (reset),
		.rx_newhead        (rx_newhead),
		.rx_dven           (rx_dven),
		.rx_error          (rx_error),
		.rx_data           (rx_data),
		.rx_dstport        (rx_dstport),
		.rx_srcport        (rx_srcport),
		.rx_length         (rx_length),
		.reply_srcport     (tx_srcport),	// our port goes out as source
		.reply_dstport     (tx_dstport),
		.rx_payload_length (rx_payload_length),
		.rx_err_count      (rx_err_count),
		.bytes             (rx_bytes.source)
	);

	rx_word_packer u_packer (
		.clk        (clk),
		.reset      (reset),
		.bytes      (rx_bytes.sink),
		.lb_rx_data (lb_rx_data),
		.lb_rx_dv   (lb_rx_dv)
	);

	tx_word_fifo u_tx_fifo (
		.clk        (clk),
		.reset      (reset),
		.lb_tx_data (lb_tx_data),
		.lb_tx_en   (lb_tx_en),
		.rd         (tx_rd.source)
	);

	udp_tx_sequencer u_tx_seq (
		.clk           (clk),
		.reset         (reset),
		.tx_length     (tx_length),
		.udp_ack       (udp_ack),
		.rd            (tx_rd.sink),
		.udp_request   (udp_request),
		.tx_data       (tx_data),
		.tx_dven       (tx_dven),
		.tx_error      (tx_error),
		.tx_udp_length (tx_udp_length)
	);

endmodule

`default_nettype wire

//--- tb/udp_lb_bridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module udp_lb_bridge_tb
	import udp_lb_pkg::*;
();

	typedef struct packed {
		logic        is_tx;
		logic [15:0] dstport;
		logic [15:0] srcport;
		logic [15:0] nbytes;	// payload bytes on receive, tx_length on transmit
		logic [7:0]  nerr;
		logic [7:0]  ack_delay;
		logic [3:0]  words;
	} test_t;

	logic clk = 1'b0;
	logic reset;
	logic rx_newhead, rx_dven, rx_error, udp_ack, lb_tx_en;
	logic [7:0]  rx_data;
	logic [15:0] rx_dstport, rx_srcport, rx_length, tx_length;
	logic [63:0] lb_tx_data;
	logic [15:0] tx_srcport, tx_dstport, tx_udp_length, rx_payload_length, rx_err_count;
	logic [7:0]  tx_data;
	logic        tx_dven, tx_error, udp_request, lb_rx_dv;
	logic [63:0] lb_rx_data;

	test_t       tests [9];
	logic [63:0] rx_words [$];
	logic [63:0] exp_words [$];
	logic [7:0]  tx_bytes [$];
	logic [7:0]  fifo_model [$];	// bytes the local bus has written and the engine not yet taken
	logic [31:0] lcg_state = 32'h9859_01ef;
	logic [15:0] last_src, exp_len, exp_err;
	int          req_count = 0;
	int          req_used = 0;
	int          err_pulses = 0;
	int          errors = 0;
	int          passed = 0;
	int          i, errs_before;

	udp_lb_bridge dut0 (.*);

	always #10 clk = ~clk;

	// outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (lb_rx_dv)
				rx_words.push_back(lb_rx_data);
			if (tx_dven)
				tx_bytes.push_back(tx_data);
			if (udp_request)
				req_count++;
			if (tx_error)
				err_pulses++;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Mismatch %s: got %h, expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s did not happen within 2000 cycles", what);
		errors++;
	endtask

	task automatic run_rx(input test_t t);
		logic [63:0] word;
		int k;
		int cnt;
		bit match;
		match = (t.dstport == LOCAL_PORT);
		rx_words.delete();
		exp_words.delete();
		word = '0;
		rx_newhead = 1'b1;
		rx_dstport = t.dstport;
		rx_srcport = t.srcport;
		rx_length = t.nbytes + 16'd8;
		next_cycle;
		rx_newhead = 1'b0;
		for (k = 0; k < t.nbytes; k++) begin
			lcg_state = lcg_next(lcg_state);
			rx_data = lcg_state[23:16];
			rx_dven = 1'b1;
			rx_error = (k < t.nerr);
			word[(k % 8) * 8 +: 8] = rx_data;	// lsb first, unused lanes stay zero
			if (k % 8 == 7 || k == t.nbytes - 1) begin
				exp_words.push_back(word);
				word = '0;
			end
			next_cycle;
		end
		rx_dven = 1'b0;
		rx_error = 1'b0;
		if (!match)
			exp_words.delete();	// foreign frames reach nothing
		for (cnt = 0; cnt < 2000 && rx_words.size() < exp_words.size(); cnt++)
			next_cycle;
		if (rx_words.size() < exp_words.size())
			report_timeout("lb_rx_dv for every word");
		repeat (8) next_cycle;
		if (rx_words.size() != exp_words.size())
			report_mismatch("lb_rx_dv pulses", rx_words.size(), exp_words.size());
		else
			for (k = 0; k < exp_words.size(); k++)
				if (rx_words[k] != exp_words[k])
					report_mismatch("lb_rx_data", rx_words[k], exp_words[k]);
		if (match) begin
			last_src = t.srcport;
			exp_len = t.nbytes;
			exp_err = t.nerr;
		end
		if (rx_payload_length != exp_len)
			report_mismatch("rx_payload_length", rx_payload_length, exp_len);
		if (rx_err_count != exp_err)
			report_mismatch("rx_err_count", rx_err_count, exp_err);
		if (tx_dstport != last_src)
			report_mismatch("tx_dstport", tx_dstport, last_src);
		if (tx_srcport != LOCAL_PORT)
			report_mismatch("tx_srcport", tx_srcport, LOCAL_PORT);
	endtask

	task automatic run_tx(input test_t t);
		logic [63:0] word;
		logic [7:0]  exp_q [$];
		int k;
		int cnt;
		int err_base;
		bit short_frame;
		tx_bytes.delete();
		err_base = err_pulses;
		tx_length = t.nbytes;
		for (k = 0; k < t.words; k++) begin
			lcg_state = lcg_next(lcg_state);
			word[31:0] = lcg_state;
			lcg_state = lcg_next(lcg_state);
			word[63:32] = lcg_state;
			lb_tx_data = word;
			lb_tx_en = 1'b1;
			for (cnt = 0; cnt < 8; cnt++)
				fifo_model.push_back(word[cnt * 8 +: 8]);
			next_cycle;
		end
		lb_tx_en = 1'b0;
		short_frame = (t.nbytes > fifo_model.size());
		while (exp_q.size() < t.nbytes && fifo_model.size() > 0)
			exp_q.push_back(fifo_model.pop_front());
		// a request may already be pending from leftover bytes
		for (cnt = 0; cnt < 2000 && req_count <= req_used; cnt++)
			next_cycle;
		if (req_count <= req_used)
			report_timeout("udp_request");
		req_used++;
		repeat (t.ack_delay) next_cycle;
		udp_ack = 1'b1;
		next_cycle;
		udp_ack = 1'b0;
		for (cnt = 0; cnt < 2000 && (tx_bytes.size() < exp_q.size() ||
			(short_frame && err_pulses == err_base)); cnt++)
			next_cycle;
		if (tx_bytes.size() < exp_q.size() || (short_frame && err_pulses == err_base))
			report_timeout("end of tx_dven");
		if (req_count != req_used)
			report_mismatch("udp_request pulses", req_count, req_used);
		if (tx_udp_length != t.nbytes + 16'd8)
			report_mismatch("tx_udp_length", tx_udp_length, t.nbytes + 16'd8);
		repeat (4) next_cycle;
		if (tx_bytes.size() != exp_q.size())
			report_mismatch("tx_dven bytes", tx_bytes.size(), exp_q.size());
		else
			for (k = 0; k < exp_q.size(); k++)
				if (tx_bytes[k] != exp_q[k])
					report_mismatch("tx_data", tx_bytes[k], exp_q[k]);
		if (err_pulses - err_base != int'(short_frame))
			report_mismatch("tx_error pulses", err_pulses - err_base, short_frame);
		if (tx_dstport != last_src)
			report_mismatch("tx_dstport", tx_dstport, last_src);
		if (tx_srcport != LOCAL_PORT)
			report_mismatch("tx_srcport", tx_srcport, LOCAL_PORT);
	endtask

	initial begin
		reset = 1'b1;
		rx_newhead = 1'b0;
		rx_dven = 1'b0;
		rx_error = 1'b0;
		rx_data = '0;
		rx_dstport = '0;
		rx_srcport = '0;
		rx_length = '0;
		udp_ack = 1'b0;
		tx_length = '0;
		lb_tx_data = '0;
		lb_tx_en = 1'b0;
		// kind, dstport, srcport, bytes, errors, ack delay, words
		tests[0] = '{1'b0, LOCAL_PORT, 16'h1234, 16'd20, 8'd2, 8'd0, 4'd0};
		tests[1] = '{1'b0, LOCAL_PORT, 16'h4321, 16'd16, 8'd0, 8'd0, 4'd0};
		tests[2] = '{1'b0, 16'h0050, 16'h9999, 16'd13, 8'd3, 8'd0, 4'd0};	// foreign
		tests[3] = '{1'b1, 16'h0000, 16'h0000, 16'd16, 8'd0, 8'd3, 4'd2};
		tests[4] = '{1'b1, 16'h0000, 16'h0000, 16'd10, 8'd0, 8'd0, 4'd2};	// 6 left over
		tests[5] = '{1'b1, 16'h0000, 16'h0000, 16'd14, 8'd0, 8'd5, 4'd1};
		tests[6] = '{1'b1, 16'h0000, 16'h0000, 16'd30, 8'd0, 8'd1, 4'd2};	// runs short
		tests[7] = '{1'b0, LOCAL_PORT, 16'habcd, 16'd5, 8'd1, 8'd0, 4'd0};
		tests[8] = '{1'b1, 16'h0000, 16'h0000, 16'd8, 8'd0, 8'd2, 4'd1};
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		next_cycle;
		for (i = 0; i < $size(tests); i++) begin
			errs_before = errors;
			if (tests[i].is_tx)
				run_tx(tests[i]);
			else
				run_rx(tests[i]);
			if (errors == errs_before)
				passed++;
			$display("test %0d (%s): %s", i, tests[i].is_tx ? "transmit" : "receive",
				errors == errs_before ? "ok" : "failed");
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", $size(tests), passed,
			$size(tests) - passed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/udp_lb_pkg.sv
hdl/udp_lb_ifs.sv
hdl/udp_rx_port_filter.sv
hdl/rx_word_packer.sv
hdl/tx_word_fifo.sv
hdl/udp_tx_sequencer.sv
hdl/udp_lb_bridge.sv
tb/udp_lb_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module udp_lb_bridge_tb -Mdir obj_dir -o udp_lb_bridge_sim

./obj_dir/udp_lb_bridge_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
